// File: flist.f
nes_host_pkg.sv
joypad_port.sv
palette_loader.sv
palette_lut.sv
reset_sequencer.sv
save_ram.sv
nes_host_bridge.sv
tb_nes_host_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_nes_host_bridge
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= All tests passed
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_nes_host_bridge.sv
module tb_nes_host_bridge
  import nes_host_pkg::*;
;

  localparam int CLK_PERIOD = 40;
  localparam int SWEEP_CYCLES = (2 ** SAVE_ADDR_W) * CLEAR_SPACING;
  // budget for two sweeps plus the shorter tests, with margin
  localparam int WATCHDOG_TIME = (2 * SWEEP_CYCLES + 4000) * CLK_PERIOD;
  localparam int PAL_EXTRA_BYTES = 8;

  logic clk_ppu_21_47;
  logic reset_nes;
  logic external_reset;
  logic download_active;
  pad_set_t pads;
  logic multitap_enabled;
  logic swap_controllers;
  logic joypad_latch;
  logic [1:0] joypad_clock;
  logic [1:0] joypad_data;
  logic palette_download;
  pal_byte_t pal_byte;
  logic pal_byte_strobe;
  logic [5:0] color_index;
  rgb_t color_rgb;
  save_wr_t save_wr;
  logic save_wr_valid;
  logic save_wr_ready;
  logic [SAVE_ADDR_W-1:0] save_rd_addr;
  logic [7:0] save_rd_data;
  logic clearing;
  logic core_reset;

  int errors = 0;
  logic [7:0] save_model [2 ** SAVE_ADDR_W];
  logic [SAVE_ADDR_W-1:0] save_addrs [$];
  logic [7:0] pal_data [PAL_FILE_BYTES + PAL_EXTRA_BYTES];

  nes_host_bridge u_nes_host_bridge (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .external_reset   (external_reset),
    .download_active  (download_active),
    .pads             (pads),
    .multitap_enabled (multitap_enabled),
    .swap_controllers (swap_controllers),
    .joypad_latch     (joypad_latch),
    .joypad_clock     (joypad_clock),
    .joypad_data      (joypad_data),
    .palette_download (palette_download),
    .pal_byte         (pal_byte),
    .pal_byte_strobe  (pal_byte_strobe),
    .color_index      (color_index),
    .color_rgb        (color_rgb),
    .save_wr          (save_wr),
    .save_wr_valid    (save_wr_valid),
    .save_wr_ready    (save_wr_ready),
    .save_rd_addr     (save_rd_addr),
    .save_rd_data     (save_rd_data),
    .clearing         (clearing),
    .core_reset       (core_reset)
  );

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: the tests did not finish within the cycle budget");
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  // inputs change 2 units after the edge, outputs are sampled there too
  task automatic next_cycle();
    @(posedge clk_ppu_21_47);
    #2;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s actual=%h expected=%h", name, actual, expected);
      $display("Some tests failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic save_write(input logic [SAVE_ADDR_W-1:0] addr, input logic [7:0] data);
    logic accepted;
    save_wr.addr = addr;
    save_wr.data = data;
    save_wr_valid = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      accepted = save_wr_ready;
      next_cycle();
    end
    save_wr_valid = 1'b0;
    save_model[addr] = data;
    save_addrs.push_back(addr);
  endtask

  task automatic save_read_check(input logic [SAVE_ADDR_W-1:0] addr);
    save_rd_addr = addr;
    next_cycle();
    check_value("save_rd_data", 32'(save_rd_data), 32'(save_model[addr]));
  endtask

  task automatic reset_hold();
    for (int i = 0; i < 8; i++) begin
      next_cycle();
      check_value("core_reset", 32'(core_reset), 32'd1);
    end
    download_active = 1'b1;
    next_cycle();
    check_value("core_reset", 32'(core_reset), 32'd1);
    save_write(10'h3ff, 8'($urandom));
    download_active = 1'b0;
    // tail counts from 255 once the edge has seen the download low
    for (int k = 1; k < DL_RESET_TAIL; k++) begin
      next_cycle();
      check_value("core_reset", 32'(core_reset), 32'd1);
      check_value("clearing", 32'(clearing), 32'd0);
    end
    next_cycle();
    check_value("core_reset", 32'(core_reset), 32'd0);
    external_reset = 1'b1;
    next_cycle();
    check_value("core_reset", 32'(core_reset), 32'd1);
    external_reset = 1'b0;
    next_cycle();
    check_value("core_reset", 32'(core_reset), 32'd0);
  endtask

  task automatic controller_shift(input logic tap, input logic swap);
    logic [31:0] pad_bits;
    logic [23:0] exp1;
    logic [23:0] exp2;
    pad_bits = $urandom;
    pads = pad_bits;
    multitap_enabled = tap;
    swap_controllers = swap;
    exp1[7:0] = swap ? pad_bits[15:8] : pad_bits[7:0];
    exp2[7:0] = swap ? pad_bits[7:0] : pad_bits[15:8];
    exp1[23:8] = tap ? {TAP_SIG_PORT1, pad_bits[23:16]} : 16'hffff;
    exp2[23:8] = tap ? {TAP_SIG_PORT2, pad_bits[31:24]} : 16'hffff;
    joypad_latch = 1'b1;
    next_cycle();
    joypad_latch = 1'b0;
    for (int n = 0; n < PAD_CHAIN_BITS + 4; n++) begin
      // chain empties to zero after the last button
      check_value("joypad_data[0]", 32'(joypad_data[0]),
                  (n < PAD_CHAIN_BITS) ? 32'(exp1[n]) : 32'd0);
      check_value("joypad_data[1]", 32'(joypad_data[1]),
                  (n < PAD_CHAIN_BITS) ? 32'(exp2[n]) : 32'd0);
      joypad_clock = 2'b11;
      next_cycle();
      joypad_clock = 2'b00;
      next_cycle();
    end
  endtask

  task automatic palette_stream();
    int idx;
    palette_download = 1'b1;
    next_cycle();
    for (int i = 0; i < PAL_FILE_BYTES + PAL_EXTRA_BYTES; i++) begin
      pal_data[i] = 8'($urandom);
      pal_byte.addr = 8'(i);
      pal_byte.data = pal_data[i];
      pal_byte_strobe = 1'b1;
      next_cycle();
      pal_byte_strobe = 1'b0;
      if (i % 5 == 4) begin
        next_cycle();
      end
    end
    repeat (3) next_cycle();
    palette_download = 1'b0;
    // full sweep first, then some random lookups
    for (int n = 0; n < PAL_ENTRIES + 16; n++) begin
      idx = (n < PAL_ENTRIES) ? n : int'($urandom % PAL_ENTRIES);
      color_index = 6'(idx);
      next_cycle();
      check_value("color_rgb", 32'(color_rgb),
                  32'({pal_data[3 * idx], pal_data[3 * idx + 1], pal_data[3 * idx + 2]}));
    end
  endtask

  task automatic save_roundtrip();
    download_active = 1'b1;
    next_cycle();
    for (int i = 0; i < 16; i++) begin
      save_write(SAVE_ADDR_W'($urandom), 8'($urandom));
    end
    download_active = 1'b0;
    for (int i = 0; i < 24; i++) begin
      next_cycle();
      check_value("clearing", 32'(clearing), 32'd0);
    end
    foreach (save_addrs[i]) begin
      save_read_check(save_addrs[i]);
    end
  endtask

  task automatic clearing_sweep();
    int cycles;
    logic [SAVE_ADDR_W-1:0] held_addr;
    logic [7:0] held_data;
    download_active = 1'b1;
    repeat (2) next_cycle();
    download_active = 1'b0;
    next_cycle();
    check_value("clearing", 32'(clearing), 32'd1);
    // host write offered at the start of the sweep and kept valid
    held_addr = save_addrs[0];
    held_data = 8'($urandom) | 8'h01;
    save_wr.addr = held_addr;
    save_wr.data = held_data;
    save_wr_valid = 1'b1;
    cycles = 0;
    while (clearing === 1'b1) begin
      check_value("save_wr_ready", 32'(save_wr_ready), 32'd0);
      check_value("core_reset", 32'(core_reset), 32'd1);
      cycles++;
      next_cycle();
    end
    check_value("sweep cycles", 32'(cycles), 32'(SWEEP_CYCLES));
    check_value("save_wr_ready", 32'(save_wr_ready), 32'd1);
    check_value("core_reset", 32'(core_reset), 32'd0);
    next_cycle();
    save_wr_valid = 1'b0;
    for (int a = 0; a < 2 ** SAVE_ADDR_W; a++) begin
      save_model[a] = 8'h00;
    end
    save_model[held_addr] = held_data;
    foreach (save_addrs[i]) begin
      save_read_check(save_addrs[i]);
    end
    for (int i = 0; i < 16; i++) begin
      save_read_check(SAVE_ADDR_W'($urandom));
    end
  endtask

  initial begin
    void'($urandom(59517));
    reset_nes = 1'b1;
    external_reset = 1'b0;
    download_active = 1'b0;
    pads = '0;
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    joypad_latch = 1'b0;
    joypad_clock = 2'b00;
    palette_download = 1'b0;
    pal_byte = '0;
    pal_byte_strobe = 1'b0;
    color_index = 6'd0;
    save_wr = '0;
    save_wr_valid = 1'b0;
    save_rd_addr = '0;
    repeat (2) @(posedge clk_ppu_21_47);
    #2;
    reset_nes = 1'b0;

    reset_hold();
    controller_shift(1'b0, 1'b0);
    controller_shift(1'b0, 1'b1);
    controller_shift(1'b1, 1'b0);
    controller_shift(1'b1, 1'b1);
    palette_stream();
    save_roundtrip();
    clearing_sweep();

    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: nes_host_bridge.sv
module nes_host_bridge
  import nes_host_pkg::*;
(
  input  logic                   clk_ppu_21_47,
  input  logic                   reset_nes,
  input  logic                   external_reset,
  input  logic                   download_active,
  input  pad_set_t               pads,
  input  logic                   multitap_enabled,
  input  logic                   swap_controllers,
  input  logic                   joypad_latch,
  input  logic [1:0]             joypad_clock,
  output logic [1:0]             joypad_data,
  input  logic                   palette_download,
  input  pal_byte_t              pal_byte,
  input  logic                   pal_byte_strobe,
  input  logic [5:0]             color_index,
  output rgb_t                   color_rgb,
  input  save_wr_t               save_wr,
  input  logic                   save_wr_valid,
  output logic                   save_wr_ready,
  input  logic [SAVE_ADDR_W-1:0] save_rd_addr,
  output logic [7:0]             save_rd_data,
  output logic                   clearing,
  output logic                   core_reset
);

  pal_entry_t pal_entry;
  logic pal_write;

  joypad_port #(.SIGNATURE(TAP_SIG_PORT1)) u_port1 (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .own_pad          (pads.p1),
    .other_pad        (pads.p2),
    .extra_pad        (pads.p3),
    .multitap_enabled (multitap_enabled),
    .swap_controllers (swap_controllers),
    .joypad_latch     (joypad_latch),
    .joypad_clock     (joypad_clock[0]),
    .joypad_data      (joypad_data[0])
  );

  joypad_port #(.SIGNATURE(TAP_SIG_PORT2)) u_port2 (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .own_pad          (pads.p2),
    .other_pad        (pads.p1),
    .extra_pad        (pads.p4),
    .multitap_enabled (multitap_enabled),
    .swap_controllers (swap_controllers),
    .joypad_latch     (joypad_latch),
    .joypad_clock     (joypad_clock[1]),
    .joypad_data      (joypad_data[1])
  );

  palette_loader u_palette_loader (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .palette_download (palette_download),
    .pal_byte         (pal_byte),
    .pal_byte_strobe  (pal_byte_strobe),
    .pal_entry        (pal_entry),
    .pal_write        (pal_write)
  );

  palette_lut u_palette_lut (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .pal_entry     (pal_entry),
    .pal_write     (pal_write),
    .color_index   (color_index),
    .color_rgb     (color_rgb)
  );

  reset_sequencer u_reset_sequencer (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .download_active (download_active),
    .external_reset  (external_reset),
    .clearing        (clearing),
    .core_reset      (core_reset)
  );

  save_ram u_save_ram (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .download_active (download_active),
    .save_wr         (save_wr),
    .save_wr_valid   (save_wr_valid),
    .save_wr_ready   (save_wr_ready),
    .save_rd_addr    (save_rd_addr),
    .save_rd_data    (save_rd_data),
    .clearing        (clearing)
  );

endmodule

// File: save_ram.sv
module save_ram
  import nes_host_pkg::*;
(
  input  logic                   clk_ppu_21_47,
  input  logic                   reset_nes,
  input  logic                   download_active,
  input  save_wr_t               save_wr,
  input  logic                   save_wr_valid,
  output logic                   save_wr_ready,
  input  logic [SAVE_ADDR_W-1:0] save_rd_addr,
  output logic [7:0]             save_rd_data,
  output logic                   clearing
);

  logic [7:0] mem [2**SAVE_ADDR_W];
  logic written;
  logic download_q;
  logic download_rise;
  logic download_fall;
  logic wr_accept;
  logic [SAVE_ADDR_W-1:0] clear_addr;
  logic [CLEAR_DIV_W-1:0] clear_div;
  logic clear_wr;
  logic mem_we;
  logic [SAVE_ADDR_W-1:0] mem_addr;
  logic [7:0] mem_din;

  assign save_wr_ready = !clearing;
  assign wr_accept = save_wr_valid && save_wr_ready;
  assign download_rise = download_active && !download_q;
  assign download_fall = !download_active && download_q;

  // one zero write at the end of each spacing window
  assign clear_wr = clearing && (clear_div == CLEAR_DIV_W'(CLEAR_SPACING - 1));

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      download_q <= 1'b0;
      written <= 1'b0;
      clearing <= 1'b0;
      clear_addr <= '0;
      clear_div <= '0;
    end else begin
      download_q <= download_active;
      if (wr_accept) begin
        written <= 1'b1;
      end else if (download_rise) begin
        written <= 1'b0;
      end
      // no save data came with this download
      if (download_fall && !written && !wr_accept) begin
        clearing <= 1'b1;
        clear_addr <= '0;
        clear_div <= '0;
      end else if (clearing) begin
        clear_div <= clear_div + 1'b1;
        if (clear_wr) begin
          clear_addr <= clear_addr + 1'b1;
          if (&clear_addr) begin
            clearing <= 1'b0;
          end
        end
      end
    end
  end

  // sweep owns the write port while clearing
  assign mem_we = clearing ? clear_wr : wr_accept;
  assign mem_addr = clearing ? clear_addr : save_wr.addr;
  assign mem_din = clearing ? 8'd0 : save_wr.data;

  always_ff @(posedge clk_ppu_21_47) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_din;
    end
    save_rd_data <= mem[save_rd_addr];
  end

  // sweep only starts with the flag clear and nothing may set it meanwhile
  no_host_write_a: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes) clearing |-> !wr_accept && !written
  );

endmodule

// File: reset_sequencer.sv
module reset_sequencer
  import nes_host_pkg::*;
(
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  input  logic download_active,
  input  logic external_reset,
  input  logic clearing,
  output logic core_reset
);

  logic seen_download;
  logic [7:0] tail_cnt;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      seen_download <= 1'b0;
      tail_cnt <= 8'd0;
    end else begin
      if (download_active) begin
        seen_download <= 1'b1;
      end
      // held at full count until the download ends
      if (download_active) begin
        tail_cnt <= 8'(DL_RESET_TAIL);
      end else if (tail_cnt != 8'd0) begin
        tail_cnt <= tail_cnt - 8'd1;
      end
    end
  end

  assign core_reset = !seen_download || download_active || (tail_cnt != 8'd0) ||
                      external_reset || clearing;

endmodule

// File: palette_lut.sv
module palette_lut
  import nes_host_pkg::*;
(
  input  logic       clk_ppu_21_47,
  input  pal_entry_t pal_entry,
  input  logic       pal_write,
  input  logic [5:0] color_index,
  output rgb_t       color_rgb
);

  rgb_t colors [PAL_ENTRIES];

  always_ff @(posedge clk_ppu_21_47) begin
    if (pal_write) begin
      colors[pal_entry.index] <= pal_entry.color;
    end
  end

  // registered lookup, one clock behind the index
  always_ff @(posedge clk_ppu_21_47) begin
    color_rgb <= colors[color_index];
  end

endmodule

// File: palette_loader.sv
module palette_loader
  import nes_host_pkg::*;
(
  input  logic       clk_ppu_21_47,
  input  logic       reset_nes,
  input  logic       palette_download,
  input  pal_byte_t  pal_byte,
  input  logic       pal_byte_strobe,
  output pal_entry_t pal_entry,
  output logic       pal_write
);

  logic [1:0] phase;
  logic [5:0] index;
  logic [7:0] red;
  logic [7:0] green;
  logic byte_ok;

  // bytes past the 64 entries are dropped
  assign byte_ok = palette_download && pal_byte_strobe &&
                   (pal_byte.addr < 8'(PAL_FILE_BYTES));

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      phase <= 2'd0;
      index <= 6'd0;
      pal_write <= 1'b0;
    end else begin
      pal_write <= 1'b0;
      if (!palette_download) begin
        phase <= 2'd0;
        index <= 6'd0;
      end else if (byte_ok) begin
        case (phase)
          2'd0: phase <= 2'd1;
          2'd1: phase <= 2'd2;
          default: begin
            // blue byte completes the entry
            phase <= 2'd0;
            index <= index + 6'd1;
            pal_write <= 1'b1;
          end
        endcase
      end
    end
  end

  // color bytes arrive red, green, blue
  always_ff @(posedge clk_ppu_21_47) begin
    if (byte_ok) begin
      case (phase)
        2'd0: red <= pal_byte.data;
        2'd1: green <= pal_byte.data;
        default: begin
          pal_entry.index <= index;
          pal_entry.color <= {red, green, pal_byte.data};
        end
      endcase
    end
  end

  // a triple needs at least three strobes
  write_single_a: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes) pal_write |=> !pal_write
  );

endmodule

// File: joypad_port.sv
module joypad_port
  import nes_host_pkg::*;
#(
  parameter logic [7:0] SIGNATURE = TAP_SIG_PORT1
) (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  input  pad_t own_pad,
  input  pad_t other_pad,
  input  pad_t extra_pad,
  input  logic multitap_enabled,
  input  logic swap_controllers,
  input  logic joypad_latch,
  input  logic joypad_clock,
  output logic joypad_data
);

  logic [PAD_CHAIN_BITS-1:0] chain;
  logic clock_q;
  logic clock_fall;
  pad_t low_pad;
  logic [15:0] upper_bytes;

  // player swap only affects the first byte
  assign low_pad = swap_controllers ? other_pad : own_pad;

  // adapter reports extra pad then its signature, otherwise all ones
  assign upper_bytes = multitap_enabled ? {SIGNATURE, extra_pad} : 16'hffff;

  assign clock_fall = clock_q && !joypad_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      chain <= '0;
      clock_q <= 1'b0;
    end else begin
      clock_q <= joypad_clock;
      // chain keeps reloading while the latch is high
      if (joypad_latch) begin
        chain <= {upper_bytes, low_pad};
      end else if (clock_fall) begin
        chain <= {1'b0, chain[PAD_CHAIN_BITS-1:1]};
      end
    end
  end

  assign joypad_data = chain[0];

  // the console samples this line at any time once running
  data_known_a: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes) !$isunknown(joypad_data)
  );

endmodule

// File: nes_host_pkg.sv
package nes_host_pkg;

  // controller chain and adapter bytes
  localparam int PAD_CHAIN_BITS = 24;
  localparam logic [7:0] TAP_SIG_PORT1 = 8'h08;
  localparam logic [7:0] TAP_SIG_PORT2 = 8'h04;

  // palette file layout
  localparam int PAL_FILE_BYTES = 192;
  localparam int PAL_ENTRIES = 64;

  // reset tail after a download, in clocks
  localparam int DL_RESET_TAIL = 255;

  // save RAM geometry and sweep pacing
  localparam int SAVE_ADDR_W = 10;
  localparam int CLEAR_SPACING = 16;
  localparam int CLEAR_DIV_W = $clog2(CLEAR_SPACING);

  // bit 0 is button a, bit 7 is dpad right
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } pad_t;

  // player 1 in the low byte
  typedef struct packed {
    pad_t p4;
    pad_t p3;
    pad_t p2;
    pad_t p1;
  } pad_set_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } pal_byte_t;

  typedef struct packed {
    logic [5:0] index;
    rgb_t color;
  } pal_entry_t;

  typedef struct packed {
    logic [SAVE_ADDR_W-1:0] addr;
    logic [7:0] data;
  } save_wr_t;

endpackage
